// ==== design/cache.sv ====
`timescale 1ns/1ps

module cache import cache_pkg::*; #(
    parameter int BLOCK_COUNT = 8
) (
    input  logic      clk,
    input  logic      proc_reset,
    input  proc_req_t req,
    output word_t     rdata,
    output logic      stall,
    output mem_req_t  mem_req,
    input  block_t    mem_rdata,
    input  logic      mem_ready
);

    localparam int INDEX_BITS = $clog2(BLOCK_COUNT);
    localparam int TAG_BITS   = LINE_BITS - INDEX_BITS;

    logic [TAG_BITS-1:0]   tag;
    logic [INDEX_BITS-1:0] index;
    offset_t               offset;

    logic                hit;
    logic                dirty;
    logic                fill;
    logic [TAG_BITS-1:0] victim_tag;
    block_t              victim_block;

    // word address is tag | index | offset
    assign offset = req.addr[OFFSET_BITS-1:0];
    assign index  = req.addr[OFFSET_BITS +: INDEX_BITS];
    assign tag    = req.addr[PROC_ADDR_BITS-1 -: TAG_BITS];

    cache_tag_store #(
        .BLOCK_COUNT(BLOCK_COUNT)
    ) i_tag_store (
        .clk        (clk),
        .proc_reset (proc_reset),
        .index      (index),
        .tag        (tag),
        .write      (req.write),
        .fill       (fill),
        .hit        (hit),
        .dirty      (dirty),
        .victim_tag (victim_tag)
    );

    cache_data_store #(
        .BLOCK_COUNT(BLOCK_COUNT)
    ) i_data_store (
        .clk          (clk),
        .index        (index),
        .offset       (offset),
        .write        (req.write),
        .hit          (hit),
        .wdata        (req.wdata),
        .fill         (fill),
        .mem_rdata    (mem_rdata),
        .rdata        (rdata),
        .victim_block (victim_block)
    );

    cache_ctrl #(
        .TAG_BITS(TAG_BITS)
    ) i_ctrl (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .req          (req),
        .hit          (hit),
        .dirty        (dirty),
        .victim_tag   (victim_tag),
        .victim_block (victim_block),
        .mem_ready    (mem_ready),
        .fill         (fill),
        .stall        (stall),
        .mem_req      (mem_req)
    );

endmodule

// ==== design/cache_ctrl.sv ====
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; #(
    parameter int TAG_BITS = 25
) (
    input  logic                clk,
    input  logic                proc_reset,
    input  proc_req_t           req,
    input  logic                hit,
    input  logic                dirty,
    input  logic [TAG_BITS-1:0] victim_tag,
    input  block_t              victim_block,
    input  logic                mem_ready,
    output logic                fill,
    output logic                stall,
    output mem_req_t            mem_req
);

    localparam int INDEX_BITS = LINE_BITS - TAG_BITS;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic       mem_read_q;
    logic       mem_write_q;
    line_addr_t mem_addr_q;
    block_t     mem_wdata_q;
    mem_req_t   mem_req_d;

    logic       active;
    line_addr_t req_line;
    line_addr_t victim_line;

    assign active   = req.read || req.write;
    assign req_line = req.addr[PROC_ADDR_BITS-1:OFFSET_BITS];

    // same index, tag taken from the evicted entry
    assign victim_line = {victim_tag, req_line[INDEX_BITS-1:0]};

    always_comb begin
        state_d   = state_q;
        mem_req_d = mem_req;
        case (state_q)
            S_IDLE: begin
                if (active && !hit) begin
                    if (dirty) begin
                        state_d         = S_WRITEBACK;
                        mem_req_d.read  = 1'b0;
                        mem_req_d.write = 1'b1;
                        mem_req_d.addr  = victim_line;
                        mem_req_d.wdata = victim_block;
                    end else begin
                        state_d         = S_ALLOCATE;
                        mem_req_d.read  = 1'b1;
                        mem_req_d.write = 1'b0;
                        mem_req_d.addr  = req_line;
                    end
                end
            end
            S_WRITEBACK: begin
                if (mem_ready) begin  // write done, fetch new block
                    state_d         = S_ALLOCATE;
                    mem_req_d.read  = 1'b1;
                    mem_req_d.write = 1'b0;
                    mem_req_d.addr  = req_line;
                end
            end
            S_ALLOCATE: begin
                if (mem_ready) begin
                    state_d         = S_IDLE;
                    mem_req_d.read  = 1'b0;
                    mem_req_d.write = 1'b0;
                end
            end
            default: begin
                state_d         = S_IDLE;
                mem_req_d.read  = 1'b0;
                mem_req_d.write = 1'b0;
            end
        endcase
    end

    assign fill = (state_q == S_ALLOCATE) && mem_ready;

    always_comb begin
        case (state_q)
            S_IDLE:      stall = active && !hit;
            S_WRITEBACK: stall = 1'b1;
            S_ALLOCATE:  stall = !mem_ready; // released in the fill cycle
            default:     stall = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (proc_reset) begin
            state_q     <= S_IDLE;
            mem_read_q  <= 1'b0;
            mem_write_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            mem_read_q  <= mem_req_d.read;
            mem_write_q <= mem_req_d.write;
        end
    end

    // request payload
    always_ff @(posedge clk) begin
        mem_addr_q  <= mem_req_d.addr;
        mem_wdata_q <= mem_req_d.wdata;
    end

    always_comb begin
        mem_req.read  = mem_read_q;
        mem_req.write = mem_write_q;
        mem_req.addr  = mem_addr_q;
        mem_req.wdata = mem_wdata_q;
    end

endmodule

// ==== design/cache_data_store.sv ====
`timescale 1ns/1ps

module cache_data_store import cache_pkg::*; #(
    parameter int BLOCK_COUNT = 8,
    localparam int INDEX_BITS = $clog2(BLOCK_COUNT)
) (
    input  logic                  clk,
    input  logic [INDEX_BITS-1:0] index,
    input  offset_t               offset,
    input  logic                  write,
    input  logic                  hit,
    input  word_t                 wdata,
    input  logic                  fill,
    input  block_t                mem_rdata,
    output word_t                 rdata,
    output block_t                victim_block
);

    block_t blocks_q [BLOCK_COUNT];

    block_t stored_block;
    block_t fill_block;

    function automatic word_t select_word(block_t blk, offset_t off);
        return blk[off*WORD_BITS +: WORD_BITS];
    endfunction

    assign stored_block = blocks_q[index];
    assign victim_block = stored_block;

    // during fill the word comes straight from memory
    assign rdata = fill ? select_word(mem_rdata, offset)
                        : select_word(stored_block, offset);

    // incoming block with processor word merged in on a write miss
    always_comb begin
        fill_block = mem_rdata;
        if (write) begin
            fill_block[offset*WORD_BITS +: WORD_BITS] = wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            blocks_q[index] <= fill_block;
        end else if (write && hit) begin
            blocks_q[index][offset*WORD_BITS +: WORD_BITS] <= wdata;
        end
    end

endmodule

// ==== design/cache_pkg.sv ====
package cache_pkg;

    localparam int WORD_BITS       = 32;
    localparam int WORDS_PER_BLOCK = 4;
    localparam int OFFSET_BITS     = $clog2(WORDS_PER_BLOCK);
    localparam int PROC_ADDR_BITS  = 30;
    localparam int LINE_BITS       = PROC_ADDR_BITS - OFFSET_BITS; // block address width

    typedef logic [WORD_BITS-1:0]                 word_t;
    typedef logic [WORDS_PER_BLOCK*WORD_BITS-1:0] block_t;
    typedef logic [PROC_ADDR_BITS-1:0]            proc_addr_t;
    typedef logic [LINE_BITS-1:0]                 line_addr_t;
    typedef logic [OFFSET_BITS-1:0]               offset_t;

    // processor side, held until stall is low
    typedef struct packed {
        logic       read;
        logic       write;
        proc_addr_t addr;
        word_t      wdata;
    } proc_req_t;

    // memory side, one block per transfer
    typedef struct packed {
        logic       read;
        logic       write;
        line_addr_t addr;
        block_t     wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        S_IDLE,
        S_WRITEBACK,  // old dirty block going out
        S_ALLOCATE    // new block coming in
    } ctrl_state_e;

endpackage

// ==== design/cache_tag_store.sv ====
`timescale 1ns/1ps

module cache_tag_store import cache_pkg::*; #(
    parameter int BLOCK_COUNT = 8,
    localparam int INDEX_BITS = $clog2(BLOCK_COUNT),
    localparam int TAG_BITS   = LINE_BITS - INDEX_BITS
) (
    input  logic                  clk,
    input  logic                  proc_reset,
    input  logic [INDEX_BITS-1:0] index,
    input  logic [TAG_BITS-1:0]   tag,
    input  logic                  write,
    input  logic                  fill,
    output logic                  hit,
    output logic                  dirty,
    output logic [TAG_BITS-1:0]   victim_tag
);

    logic [BLOCK_COUNT-1:0] valid_q;
    logic [BLOCK_COUNT-1:0] dirty_q;
    logic [TAG_BITS-1:0]    tag_q [BLOCK_COUNT];

    logic entry_valid;
    logic [TAG_BITS-1:0] entry_tag;

    assign entry_valid = valid_q[index];
    assign entry_tag   = tag_q[index];

    assign hit        = entry_valid && (entry_tag == tag);
    assign dirty      = entry_valid && dirty_q[index]; // victim needs write-back
    assign victim_tag = entry_tag;

    // valid and dirty bits
    always_ff @(posedge clk) begin
        if (proc_reset) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill) begin
            valid_q[index] <= 1'b1;
            dirty_q[index] <= write;  // write miss leaves block dirty
        end else if (write && hit) begin
            dirty_q[index] <= 1'b1;
        end
    end

    // tags only change on a fill
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_q[index] <= tag;
        end
    end

endmodule

// ==== project.f ====
design/cache_pkg.sv
design/cache_tag_store.sv
design/cache_data_store.sv
design/cache_ctrl.sv
design/cache.sv
test/cache_mem_model.sv
test/cache_tb.sv

// ==== test/cache_mem_model.sv ====
`timescale 1ns/1ps

module cache_mem_model import cache_pkg::*; #(
    parameter int LINE_COUNT = 64
) (
    input  logic     clk,
    input  logic     proc_reset,
    input  mem_req_t mem_req,
    output block_t   mem_rdata,
    output logic     mem_ready
);

    localparam int LINE_IDX_BITS = $clog2(LINE_COUNT);

    block_t mem [LINE_COUNT];

    logic busy;
    int   delay_left;

    // every word holds a value built from its own full word address
    function automatic word_t pattern_word(proc_addr_t addr);
        return {addr, 2'b11} ^ 32'h9e37_79b9;
    endfunction

    initial begin
        for (int line = 0; line < LINE_COUNT; line++) begin
            for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
                mem[line][w*WORD_BITS +: WORD_BITS] =
                    pattern_word(proc_addr_t'(line * WORDS_PER_BLOCK + w));
            end
        end
        mem_rdata  = '0;
        mem_ready  = 1'b0;
        busy       = 1'b0;
        delay_left = 0;
    end

    // responses change on the falling edge
    always @(negedge clk) begin
        if (proc_reset) begin
            mem_ready  <= 1'b0;
            busy       <= 1'b0;
            delay_left <= 0;
        end else if (mem_ready) begin
            mem_ready <= 1'b0;  // one-cycle pulse
        end else if (mem_req.read || mem_req.write) begin
            if (!busy) begin
                busy       <= 1'b1;
                delay_left <= $urandom_range(1, 4);
            end else if (delay_left > 1) begin
                delay_left <= delay_left - 1;
            end else begin
                busy      <= 1'b0;
                mem_ready <= 1'b1;
                if (mem_req.write) begin
                    mem[mem_req.addr[LINE_IDX_BITS-1:0]] <= mem_req.wdata;
                end else begin
                    mem_rdata <= mem[mem_req.addr[LINE_IDX_BITS-1:0]];
                end
            end
        end
    end

endmodule

// ==== test/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb import cache_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int BLOCK_COUNT  = 8;
    localparam int INDEX_BITS   = $clog2(BLOCK_COUNT);
    localparam int NUM_REQ      = 400;
    localparam int TAG_POOL     = 4;  // tags 0..3 fight over every index
    localparam int FRESH_TAG    = 6;  // kept away from random traffic
    localparam int MEM_LINES    = 64;
    localparam int GOLDEN_WORDS = MEM_LINES * WORDS_PER_BLOCK;
    localparam int MISS_CYCLES  = 14; // write-back plus fetch at the longest delay
    localparam int REQ_CYCLES   = MISS_CYCLES + 4;
    localparam int TIMEOUT_NS   =
        (RESET_CYCLES + (NUM_REQ + 8) * REQ_CYCLES + 100) * CLK_PERIOD;

    logic      clk;
    logic      proc_reset;
    proc_req_t req;
    word_t     rdata;
    logic      stall;
    mem_req_t  mem_req;
    block_t    mem_rdata;
    logic      mem_ready;

    word_t golden    [GOLDEN_WORDS];
    logic  ref_valid [BLOCK_COUNT];
    logic  ref_dirty [BLOCK_COUNT];
    int    ref_tag   [BLOCK_COUNT];

    logic       xfer_write_q [$];
    line_addr_t xfer_addr_q  [$];
    block_t     xfer_data_q  [$];

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    cache #(
        .BLOCK_COUNT(BLOCK_COUNT)
    ) i_cache (
        .clk        (clk),
        .proc_reset (proc_reset),
        .req        (req),
        .rdata      (rdata),
        .stall      (stall),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    cache_mem_model #(
        .LINE_COUNT(MEM_LINES)
    ) i_mem (
        .clk        (clk),
        .proc_reset (proc_reset),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready)
    );

    // log every completed memory transfer
    always @(posedge clk) begin
        if (!proc_reset && mem_ready && (mem_req.read || mem_req.write)) begin
            xfer_write_q.push_back(mem_req.write);
            xfer_addr_q.push_back(mem_req.addr);
            xfer_data_q.push_back(mem_req.wdata);
        end
    end

    function automatic word_t pattern_word(proc_addr_t addr);
        return {addr, 2'b11} ^ 32'h9e37_79b9;
    endfunction

    function automatic block_t golden_block(int line);
        block_t blk;
        for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
            blk[w*WORD_BITS +: WORD_BITS] = golden[line * WORDS_PER_BLOCK + w];
        end
        return blk;
    endfunction

    function automatic proc_addr_t make_addr(int tag, int idx, int off);
        return proc_addr_t'((tag * BLOCK_COUNT + idx) * WORDS_PER_BLOCK + off);
    endfunction

    task automatic check(input string name, input logic [159:0] got,
                         input logic [159:0] expected);
        if (got !== expected) begin
            $display("ERR %0t %s got %0h expected %0h", $time, name, got, expected);
            $display("TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // called on a falling edge, returns on a falling edge with req idle
    task automatic run_request(input logic is_write, input proc_addr_t addr,
                               input word_t wdata, output word_t rdata_out);
        int    idx;
        int    tg;
        int    line;
        int    cycles;
        logic  pred_hit;
        logic  pred_wb;
        logic  got_stall;
        word_t got_rdata;
        idx      = int'(addr[OFFSET_BITS +: INDEX_BITS]);
        tg       = int'(addr >> (OFFSET_BITS + INDEX_BITS));
        line     = int'(addr >> OFFSET_BITS);
        pred_hit = ref_valid[idx] && (ref_tag[idx] == tg);
        pred_wb  = !pred_hit && ref_valid[idx] && ref_dirty[idx];
        xfer_write_q.delete();
        xfer_addr_q.delete();
        xfer_data_q.delete();
        req.read  = !is_write;
        req.write = is_write;
        req.addr  = addr;
        req.wdata = wdata;
        cycles    = 0;
        do begin
            @(posedge clk);
            got_stall = stall;
            got_rdata = rdata;
            cycles++;
        end while (got_stall);
        @(negedge clk);
        req = '0;
        // nothing left requested once the access is done
        check("mem_req.read", mem_req.read, 1'b0);
        check("mem_req.write", mem_req.write, 1'b0);
        if (pred_hit) begin
            check("hit_cycles", cycles, 1);
        end else if (pred_wb) begin
            check("mem_transfers", xfer_write_q.size(), 2);
            check("mem_req.write", xfer_write_q[0], 1'b1);
            check("mem_req.addr", xfer_addr_q[0], ref_tag[idx] * BLOCK_COUNT + idx);
            check("mem_req.wdata", xfer_data_q[0],
                  golden_block(ref_tag[idx] * BLOCK_COUNT + idx));
            check("mem_req.write", xfer_write_q[1], 1'b0);
            check("mem_req.addr", xfer_addr_q[1], line);
        end else begin
            check("mem_transfers", xfer_write_q.size(), 1);
            check("mem_req.write", xfer_write_q[0], 1'b0);
            check("mem_req.addr", xfer_addr_q[0], line);
        end
        if (!is_write) begin
            check("rdata", got_rdata, golden[int'(addr)]);
        end else begin
            golden[int'(addr)] = wdata;
        end
        if (!pred_hit) begin
            ref_valid[idx] = 1'b1;
            ref_tag[idx]   = tg;
            ref_dirty[idx] = is_write;  // write miss merges and stays dirty
        end else if (is_write) begin
            ref_dirty[idx] = 1'b1;
        end
        rdata_out = got_rdata;
    endtask

    initial begin
        logic       is_write;
        proc_addr_t addr;
        proc_addr_t fresh_addr;
        proc_addr_t neighbor_addr;
        word_t      fresh_data;
        word_t      got;
        void'($urandom(32'hbb8d));
        proc_reset = 1'b1;
        req        = '0;
        for (int a = 0; a < GOLDEN_WORDS; a++) begin
            golden[a] = pattern_word(proc_addr_t'(a));
        end
        for (int i = 0; i < BLOCK_COUNT; i++) begin
            ref_valid[i] = 1'b0;
            ref_dirty[i] = 1'b0;
            ref_tag[i]   = 0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        proc_reset = 1'b0;
        @(posedge clk);
        check("stall", stall, 1'b0);
        check("mem_req.read", mem_req.read, 1'b0);
        check("mem_req.write", mem_req.write, 1'b0);
        @(negedge clk);

        for (int n = 0; n < NUM_REQ; n++) begin
            is_write = 1'($urandom_range(0, 1));
            addr     = make_addr($urandom_range(0, TAG_POOL - 1),
                                 $urandom_range(0, BLOCK_COUNT - 1),
                                 $urandom_range(0, WORDS_PER_BLOCK - 1));
            run_request(is_write, addr, $urandom, got);
            repeat ($urandom_range(0, 2)) @(negedge clk);
        end

        // write miss on an untouched line, then a neighbour word and the word itself
        fresh_addr    = make_addr(FRESH_TAG, 5, 1);
        neighbor_addr = make_addr(FRESH_TAG, 5, 2);
        fresh_data    = $urandom;
        run_request(1'b1, fresh_addr, fresh_data, got);
        run_request(1'b0, neighbor_addr, $urandom, got);
        check("rdata", got, pattern_word(neighbor_addr));
        run_request(1'b0, fresh_addr, $urandom, got);
        check("rdata", got, fresh_data);

        $display("TESTS PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule
